//--- flist.f
+incdir+.
card_pkg.sv
game_pkg.sv
player_input.sv
card_dealer.sv
hand_tracker.sv
game_sequencer.sv
settlement_unit.sv
blackjack_top.sv
tb_blackjack.sv

//--- tb_blackjack.sv
`timescale 1ns/100ps
`include "blackjack_defs.svh"

module tb_blackjack;

    localparam int CYCLE_LIMIT = 2000;
    localparam int WAIT_LIMIT  = 60;

    localparam int BTN_NEXT   = 0;
    localparam int BTN_HIT    = 1;
    localparam int BTN_STAND  = 2;
    localparam int BTN_DOUBLE = 3;

    localparam int MODE_STAND  = 0;
    localparam int MODE_HIT    = 1;
    localparam int MODE_DOUBLE = 2;

    logic               clk;
    logic               reset;
    logic               next;
    logic               hit;
    logic               stand;
    logic               double_down;
    game_pkg::bet_t     bet;
    card_pkg::hand_t    player_hand;
    card_pkg::hand_t    dealer_hand;
    game_pkg::phase_e   phase;
    game_pkg::outcome_t result;
    game_pkg::coin_t    coins;

    int cycles = 0;

    // reference model state, index 0 is the player and 1 the dealer
    logic [15:0] m_lfsr;
    int          m_coins;
    int          m_hard[2];
    int          m_cards[2];
    bit          m_ace[2];

    blackjack_top blackjack_top_inst (
        .clk(clk), .reset(reset), .next(next), .hit(hit), .stand(stand),
        .double_down(double_down), .bet(bet), .player_hand(player_hand),
        .dealer_hand(dealer_hand), .phase(phase), .result(result), .coins(coins)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int card_value(input logic [15:0] s);
        int rank;
        rank = (int'(s) % `BJ_CARD_RANKS) + 1;
        return (rank > 10) ? 10 : rank;
    endfunction

    function automatic int model_total(input int who);
        if (m_ace[who] && m_hard[who] + `BJ_ACE_BONUS <= `BJ_TARGET) begin
            return m_hard[who] + `BJ_ACE_BONUS;
        end
        return m_hard[who];
    endfunction

    task automatic model_draw(input int who);
        int value;
        value = card_value(m_lfsr);
        m_lfsr = lfsr_step(m_lfsr);
        m_hard[who] += value;
        if (m_cards[who] < 7) begin
            m_cards[who]++;
        end
        if (value == 1) begin
            m_ace[who] = 1'b1;
        end
    endtask

    // {win, lose, draw, natural}
    function automatic logic [3:0] expected_outcome();
        int   p;
        int   d;
        logic win;
        logic lose;
        logic draw;
        p = model_total(0);
        d = model_total(1);
        win  = 1'b0;
        lose = 1'b0;
        draw = 1'b0;
        if (p > `BJ_TARGET) begin
            lose = 1'b1;
        end else if (d > `BJ_TARGET || p > d) begin
            win = 1'b1;
        end else if (p < d) begin
            lose = 1'b1;
        end else begin
            draw = 1'b1;
        end
        return {win, lose, draw, win && m_cards[0] == 2 && p == `BJ_TARGET};
    endfunction

    // ----------------------------------------
    // checking and stimulus helpers
    // ----------------------------------------
    task automatic check(input logic [31:0] actual, input int expected, input string what);
        if (actual !== 32'(expected)) begin
            $display("Mismatch at %0t: %s, got %0d, expected %0d", $time, what, actual,
                     expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic check_hand(input int who, input string what);
        card_pkg::hand_t h;
        h = (who == 0) ? player_hand : dealer_hand;
        check(h.total, model_total(who), {what, " total"});
        check(h.cards, m_cards[who], {what, " card count"});
    endtask

    // level high for two cycles, then one low cycle so the next press is an edge
    task automatic press_button(input int button);
        case (button)
            BTN_NEXT:  next        = 1'b1;
            BTN_HIT:   hit         = 1'b1;
            BTN_STAND: stand       = 1'b1;
            default:   double_down = 1'b1;
        endcase
        repeat (2) @(posedge clk);
        #1;
        next        = 1'b0;
        hit         = 1'b0;
        stand       = 1'b0;
        double_down = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_phase(input game_pkg::phase_e target);
        int waited;
        waited = 0;
        while (phase !== target) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("phase %s was never reached within %0d cycles", target.name(),
                         WAIT_LIMIT);
                $display("TEST RESULT: FAIL");
                $fatal(1, "phase wait timed out");
            end
        end
    endtask

    task automatic play_round(input int amount, input int mode, output bit doubled);
        int         stake;
        int         payout;
        bit         player_acts;
        logic [3:0] outcome;
        doubled = 1'b0;
        bet = game_pkg::bet_t'(amount);
        press_button(BTN_NEXT);
        m_coins -= amount;
        stake = amount;
        for (int i = 0; i < 2; i++) begin
            m_hard[i]  = 0;
            m_cards[i] = 0;
            m_ace[i]   = 1'b0;
        end
        model_draw(0);
        model_draw(0);
        model_draw(1);
        model_draw(1);
        wait_for_phase(game_pkg::PLAYER_TURN);
        check(coins, m_coins, "coins after bet");
        check_hand(0, "player after deal");
        check_hand(1, "dealer after deal");

        // a 21 on either side skips the player's turn
        player_acts = model_total(0) < `BJ_TARGET && model_total(1) != `BJ_TARGET;
        if (player_acts && mode == MODE_DOUBLE) begin
            press_button(BTN_DOUBLE);
            m_coins -= stake;
            stake *= 2;
            model_draw(0);
            doubled = 1'b1;
            check(coins, m_coins, "coins after double");
        end else if (player_acts) begin
            while (mode == MODE_HIT && model_total(0) < `BJ_DEALER_STAND) begin
                press_button(BTN_HIT);
                model_draw(0);
                check_hand(0, "player after hit");
            end
            if (model_total(0) < `BJ_TARGET) begin
                press_button(BTN_STAND);
            end
        end

        while (model_total(1) < `BJ_DEALER_STAND && model_total(0) <= `BJ_TARGET) begin
            model_draw(1);
        end
        wait_for_phase(game_pkg::SHOW);
        check_hand(0, "player at show");
        check_hand(1, "dealer at show");

        outcome = expected_outcome();
        if (outcome[0]) begin
            payout = stake * 4;
        end else if (outcome[3]) begin
            payout = stake * 2;
        end else if (outcome[1]) begin
            payout = stake;
        end else begin
            payout = 0;
        end
        m_coins = (m_coins + payout > `BJ_COIN_MAX) ? `BJ_COIN_MAX : m_coins + payout;
        check(result, outcome, "round result");
        check(coins, m_coins, "coins at show");
        press_button(BTN_NEXT);
        wait_for_phase(game_pkg::IDLE);
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    initial begin
        int amount;
        bit doubled;
        clk         = 1'b0;
        reset       = 1'b1;
        next        = 1'b0;
        hit         = 1'b0;
        stand       = 1'b0;
        double_down = 1'b0;
        bet         = '0;
        void'($urandom(32044));
        m_lfsr      = `BJ_LFSR_SEED;
        m_coins     = `BJ_START_COINS;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset state and a zero bet
        check(phase, game_pkg::IDLE, "phase after reset");
        check(coins, `BJ_START_COINS, "coins after reset");
        check(result, 0, "result after reset");
        bet = '0;
        press_button(BTN_NEXT);
        check(phase, game_pkg::IDLE, "phase after zero bet");

        // stand at once, then hit to 17
        play_round(($urandom % 5) + 1, MODE_STAND, doubled);
        play_round(($urandom % 5) + 1, MODE_HIT, doubled);

        // double down, retried while a 21 skips the player's turn
        doubled = 1'b0;
        for (int i = 0; i < 4 && !doubled; i++) begin
            play_round(4, MODE_DOUBLE, doubled);
        end
        if (!doubled) begin
            $display("no round gave the player a turn to double down");
            $display("TEST RESULT: FAIL");
            $fatal(1, "double down never tested");
        end

        // random bets
        for (int i = 0; i < 10; i++) begin
            amount = ($urandom % 15) + 1;
            if (amount > m_coins) begin
                bet = game_pkg::bet_t'(amount);
                press_button(BTN_NEXT);
                check(phase, game_pkg::IDLE, "phase after bet above balance");
                amount = m_coins;
            end
            if (amount > 0) begin
                play_round(amount, MODE_HIT, doubled);
            end
        end
        if (m_coins < 15) begin
            bet = game_pkg::bet_t'(m_coins + 1);
            press_button(BTN_NEXT);
            check(phase, game_pkg::IDLE, "phase after bet above balance");
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- blackjack_top.sv
`timescale 1ns/100ps

module blackjack_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               next,
    input  logic               hit,
    input  logic               stand,
    input  logic               double_down,
    input  game_pkg::bet_t     bet,
    output card_pkg::hand_t    player_hand,
    output card_pkg::hand_t    dealer_hand,
    output game_pkg::phase_e   phase,
    output game_pkg::outcome_t result,
    output game_pkg::coin_t    coins
);

    game_pkg::action_t actions;
    card_pkg::card_t   card;
    logic              draw;
    logic              player_add;
    logic              dealer_add;
    logic              clear_hands;
    logic              start_bet;
    logic              double_up;
    logic              settle;
    logic              bet_ok;
    logic              double_ok;

    // ----------------------------------------
    // input side
    // ----------------------------------------
    player_input player_input_inst (
        .clk(clk), .reset(reset), .next(next), .hit(hit),
        .stand(stand), .double_down(double_down), .actions(actions)
    );

    // ----------------------------------------
    // cards, hands and round control
    // ----------------------------------------
    card_dealer card_dealer_inst (
        .clk(clk), .reset(reset), .draw(draw), .card(card)
    );

    hand_tracker player_hand_inst (
        .clk(clk), .reset(reset), .clear(clear_hands), .add(player_add),
        .card(card), .hand(player_hand)
    );

    hand_tracker dealer_hand_inst (
        .clk(clk), .reset(reset), .clear(clear_hands), .add(dealer_add),
        .card(card), .hand(dealer_hand)
    );

    game_sequencer game_sequencer_inst (
        .clk(clk), .reset(reset), .actions(actions),
        .player(player_hand), .dealer(dealer_hand),
        .bet_ok(bet_ok), .double_ok(double_ok),
        .draw(draw), .player_add(player_add), .dealer_add(dealer_add),
        .clear_hands(clear_hands), .start_bet(start_bet),
        .double_up(double_up), .settle(settle), .phase(phase)
    );

    // ----------------------------------------
    // output side
    // ----------------------------------------
    settlement_unit settlement_unit_inst (
        .clk(clk), .reset(reset), .bet(bet),
        .start_bet(start_bet), .double_up(double_up), .settle(settle),
        .player(player_hand), .dealer(dealer_hand),
        .bet_ok(bet_ok), .double_ok(double_ok),
        .result(result), .coins(coins)
    );

endmodule

//--- settlement_unit.sv
`timescale 1ns/100ps
`include "blackjack_defs.svh"

module settlement_unit (
    input  logic               clk,
    input  logic               reset,
    input  game_pkg::bet_t     bet,
    input  logic               start_bet,
    input  logic               double_up,
    input  logic               settle,
    input  card_pkg::hand_t    player,
    input  card_pkg::hand_t    dealer,
    output logic               bet_ok,
    output logic               double_ok,
    output game_pkg::outcome_t result,
    output game_pkg::coin_t    coins
);

    game_pkg::coin_t    stake;
    game_pkg::coin_t    payout;
    game_pkg::outcome_t verdict;
    logic [8:0]         coin_sum;
    logic               player_bust;
    logic               dealer_bust;

    assign bet_ok    = (bet != 4'd0) && (game_pkg::coin_t'(bet) <= coins);
    assign double_ok = coins >= stake;

    // ----------------------------------------
    // judge the two hands
    // ----------------------------------------
    assign player_bust = player.total > card_pkg::score_t'(`BJ_TARGET);
    assign dealer_bust = dealer.total > card_pkg::score_t'(`BJ_TARGET);

    always_comb begin
        verdict = '0;
        if (player_bust) begin
            verdict.lose = 1'b1;
        end else if (dealer_bust || player.total > dealer.total) begin
            verdict.win = 1'b1;
        end else if (player.total < dealer.total) begin
            verdict.lose = 1'b1;
        end else begin
            verdict.draw = 1'b1;
        end
        // two-card 21
        verdict.natural = verdict.win && (player.cards == 3'd2) &&
                          (player.total == card_pkg::score_t'(`BJ_TARGET));
    end

    always_comb begin
        if (verdict.natural) begin
            payout = stake << 2;
        end else if (verdict.win) begin
            payout = stake << 1;
        end else if (verdict.draw) begin
            payout = stake;
        end else begin
            payout = '0;
        end
    end

    assign coin_sum = {1'b0, coins} + {1'b0, payout};

    // stake held for the current round
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stake <= '0;
        end else if (start_bet) begin
            stake <= game_pkg::coin_t'(bet);
        end else if (double_up) begin
            stake <= stake << 1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coins  <= game_pkg::coin_t'(`BJ_START_COINS);
            result <= '0;
        end else if (start_bet) begin
            coins  <= coins - game_pkg::coin_t'(bet);
            result <= '0;
        end else if (double_up) begin
            coins <= coins - stake;
        end else if (settle) begin
            result <= verdict;
            // balance saturates at the top
            if (coin_sum > 9'(`BJ_COIN_MAX)) begin
                coins <= game_pkg::coin_t'(`BJ_COIN_MAX);
            end else begin
                coins <= coin_sum[7:0];
            end
        end
    end

endmodule

//--- game_sequencer.sv
`timescale 1ns/100ps
`include "blackjack_defs.svh"

module game_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  game_pkg::action_t actions,
    input  card_pkg::hand_t   player,
    input  card_pkg::hand_t   dealer,
    input  logic              bet_ok,
    input  logic              double_ok,
    output logic              draw,
    output logic              player_add,
    output logic              dealer_add,
    output logic              clear_hands,
    output logic              start_bet,
    output logic              double_up,
    output logic              settle,
    output game_pkg::phase_e  phase
);

    game_pkg::phase_e phase_next;
    logic [1:0]       deal_cnt;
    logic [1:0]       deal_cnt_next;
    // player card owed after a hit or double
    logic             pend_draw;
    logic             pend_draw_next;
    logic             pend_double;
    logic             pend_double_next;
    logic             player_done;
    logic             dealer_bj;
    logic             dealer_draws;

    assign player_done  = player.total >= card_pkg::score_t'(`BJ_TARGET);
    assign dealer_bj    = dealer.total == card_pkg::score_t'(`BJ_TARGET);
    assign dealer_draws = (dealer.total < card_pkg::score_t'(`BJ_DEALER_STAND)) &&
                          (player.total <= card_pkg::score_t'(`BJ_TARGET));

    // ----------------------------------------
    // next phase and strobes
    // ----------------------------------------
    always_comb begin
        phase_next       = phase;
        deal_cnt_next    = deal_cnt;
        pend_draw_next   = pend_draw;
        pend_double_next = pend_double;
        draw             = 1'b0;
        player_add       = 1'b0;
        dealer_add       = 1'b0;
        clear_hands      = 1'b0;
        start_bet        = 1'b0;
        double_up        = 1'b0;
        settle           = 1'b0;

        case (phase)
            game_pkg::IDLE: begin
                if (actions.next && bet_ok) begin
                    start_bet     = 1'b1;
                    clear_hands   = 1'b1;
                    deal_cnt_next = 2'd0;
                    phase_next    = game_pkg::DEAL;
                end
            end
            game_pkg::DEAL: begin
                // player, player, dealer, dealer
                draw          = 1'b1;
                player_add    = ~deal_cnt[1];
                dealer_add    = deal_cnt[1];
                deal_cnt_next = deal_cnt + 2'd1;
                if (deal_cnt == 2'd3) begin
                    phase_next = game_pkg::PLAYER_TURN;
                end
            end
            game_pkg::PLAYER_TURN: begin
                if (pend_draw) begin
                    draw             = 1'b1;
                    player_add       = 1'b1;
                    pend_draw_next   = 1'b0;
                    pend_double_next = 1'b0;
                    if (pend_double) begin
                        phase_next = game_pkg::DEALER_TURN;
                    end
                end else if (player_done || dealer_bj || actions.stand) begin
                    phase_next = game_pkg::DEALER_TURN;
                end else if (actions.double_down && double_ok) begin
                    double_up        = 1'b1;
                    pend_draw_next   = 1'b1;
                    pend_double_next = 1'b1;
                end else if (actions.hit) begin
                    pend_draw_next = 1'b1;
                end
            end
            game_pkg::DEALER_TURN: begin
                // one card per cycle, hand updates before the next check
                if (dealer_draws) begin
                    draw       = 1'b1;
                    dealer_add = 1'b1;
                end else begin
                    phase_next = game_pkg::SETTLE;
                end
            end
            game_pkg::SETTLE: begin
                settle     = 1'b1;
                phase_next = game_pkg::SHOW;
            end
            game_pkg::SHOW: begin
                if (actions.next) begin
                    phase_next = game_pkg::IDLE;
                end
            end
            default: begin
                phase_next = game_pkg::IDLE;
            end
        endcase
    end

    // ----------------------------------------
    // state registers
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase       <= game_pkg::IDLE;
            deal_cnt    <= 2'd0;
            pend_draw   <= 1'b0;
            pend_double <= 1'b0;
        end else begin
            phase       <= phase_next;
            deal_cnt    <= deal_cnt_next;
            pend_draw   <= pend_draw_next;
            pend_double <= pend_double_next;
        end
    end

endmodule

//--- hand_tracker.sv
`timescale 1ns/100ps
`include "blackjack_defs.svh"

module hand_tracker (
    input  logic              clk,
    input  logic              reset,
    input  logic              clear,
    input  logic              add,
    input  card_pkg::card_t   card,
    output card_pkg::hand_t   hand
);

    card_pkg::score_t hard_sum;
    card_pkg::score_t soft_sum;
    card_pkg::count_t count;
    logic             has_ace;

    // ----------------------------------------
    // accumulate cards
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hard_sum <= '0;
            count    <= '0;
            has_ace  <= 1'b0;
        end else if (clear) begin
            hard_sum <= '0;
            count    <= '0;
            has_ace  <= 1'b0;
        end else if (add) begin
            hard_sum <= hard_sum + {2'b00, card};
            if (count != 3'd7) begin
                count <= count + 3'd1;
            end
            if (card == 4'd1) begin
                has_ace <= 1'b1;
            end
        end
    end

    // one ace may count eleven if it does not bust
    assign soft_sum = hard_sum + card_pkg::score_t'(`BJ_ACE_BONUS);

    assign hand.total = (has_ace && soft_sum <= card_pkg::score_t'(`BJ_TARGET)) ?
                        soft_sum : hard_sum;
    assign hand.cards = count;

endmodule

//--- card_dealer.sv
`timescale 1ns/100ps
`include "blackjack_defs.svh"

module card_dealer (
    input  logic              clk,
    input  logic              reset,
    input  logic              draw,
    output card_pkg::card_t   card
);

    logic [15:0] lfsr;
    logic        feedback;
    logic [15:0] rank_mod;
    logic [3:0]  rank;

    // fibonacci taps 16, 14, 13, 11
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= `BJ_LFSR_SEED;
        end else if (draw) begin
            lfsr <= {lfsr[14:0], feedback};
        end
    end

    // rank 1..13 from the current state
    assign rank_mod = lfsr % 16'(`BJ_CARD_RANKS);
    assign rank     = rank_mod[3:0] + 4'd1;

    // jack, queen and king count as ten
    assign card = (rank > 4'd10) ? card_pkg::card_t'(4'd10) : card_pkg::card_t'(rank);

endmodule

//--- player_input.sv
`timescale 1ns/100ps

module player_input (
    input  logic              clk,
    input  logic              reset,
    input  logic              next,
    input  logic              hit,
    input  logic              stand,
    input  logic              double_down,
    output game_pkg::action_t actions
);

    game_pkg::action_t level_now;
    game_pkg::action_t level_prev;

    // gather the buttons into one struct
    assign level_now.next        = next;
    assign level_now.hit         = hit;
    assign level_now.stand       = stand;
    assign level_now.double_down = double_down;

    // ----------------------------------------
    // rising edge to one-cycle pulse
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            level_prev <= '0;
            actions    <= '0;
        end else begin
            level_prev <= level_now;
            // held button acts only once
            actions    <= game_pkg::action_t'(level_now & ~level_prev);
        end
    end

endmodule

//--- game_pkg.sv
package game_pkg;

    // round phases
    typedef enum logic [2:0] {
        IDLE,
        DEAL,
        PLAYER_TURN,
        DEALER_TURN,
        SETTLE,
        SHOW
    } phase_e;

    // one-cycle button pulses
    typedef struct packed {
        logic next;
        logic hit;
        logic stand;
        logic double_down;
    } action_t;

    typedef logic [3:0] bet_t;
    typedef logic [7:0] coin_t;

    // judged result, held until the next round starts
    typedef struct packed {
        logic win;
        logic lose;
        logic draw;
        logic natural;
    } outcome_t;

endpackage

//--- card_pkg.sv
package card_pkg;

    // card value, ace counts as 1 here
    typedef logic [3:0] card_t;

    // hand total, wide enough for a busted hand
    typedef logic [5:0] score_t;

    // number of cards held, saturates at 7
    typedef logic [2:0] count_t;

    // reported state of one hand
    typedef struct packed {
        score_t total;
        count_t cards;
    } hand_t;

endpackage

//--- blackjack_defs.svh
`ifndef BLACKJACK_DEFS_SVH
`define BLACKJACK_DEFS_SVH

// ----------------------------------------
// table rules
// ----------------------------------------

// bust limit
`define BJ_TARGET 21

// dealer stops drawing at this total
`define BJ_DEALER_STAND 17

// extra value of a soft ace
`define BJ_ACE_BONUS 10

// ----------------------------------------
// coins and card source
// ----------------------------------------

`define BJ_START_COINS 30
`define BJ_COIN_MAX 255

// lfsr state after reset, must be nonzero
`define BJ_LFSR_SEED 16'hACE1
`define BJ_CARD_RANKS 13

`endif
